//--- hw/rv_dpath_pkg.sv
// Widths, select codes and stage structs shared by the scalar datapath
// Select codes must match the encodings the external controller drives
package rv_dpath_pkg;

  localparam int WORD_W    = 32;
  localparam int REG_IDX_W = 5;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [3:0]           alu_fn_t;
  typedef logic [1:0]           pc_sel_t;
  typedef logic [1:0]           op0_sel_t;
  typedef logic [2:0]           op1_sel_t;
  typedef logic [2:0]           byp_sel_t;
  typedef logic [2:0]           load_sel_t;

  localparam word_t RESET_VECTOR = 32'h0008_0000;

  // PC source
  localparam pc_sel_t PC_PLUS4 = 2'd0, PC_BRANCH = 2'd1, PC_JUMP = 2'd2, PC_JUMPREG = 2'd3;

  // Operand selects
  localparam op0_sel_t OP0_RS1 = 2'd0, OP0_PC = 2'd1, OP0_PC4 = 2'd2, OP0_ZERO = 2'd3;
  localparam op1_sel_t OP1_RS2 = 3'd0, OP1_SHAMT = 3'd1, OP1_IMM_U = 3'd2, OP1_IMM_SB = 3'd3;
  localparam op1_sel_t OP1_IMM_I = 3'd4, OP1_IMM_S = 3'd5, OP1_ZERO = 3'd6;

  // Forwarding sources, youngest first after the register file
  localparam byp_sel_t BYP_RF = 3'd0, BYP_X = 3'd1, BYP_M = 3'd2;
  localparam byp_sel_t BYP_X2 = 3'd3, BYP_X3 = 3'd4, BYP_W = 3'd5;

  // Load extension
  localparam load_sel_t LD_W = 3'd0, LD_B = 3'd1, LD_BU = 3'd2, LD_H = 3'd3, LD_HU = 3'd4;

  // ALU functions
  localparam alu_fn_t ALU_ADD = 4'd0, ALU_SUB = 4'd1, ALU_SLL = 4'd2, ALU_SLT = 4'd3;
  localparam alu_fn_t ALU_SLTU = 4'd4, ALU_XOR = 4'd5, ALU_SRL = 4'd6, ALU_SRA = 4'd7;
  localparam alu_fn_t ALU_OR = 4'd8, ALU_AND = 4'd9, ALU_COPY1 = 4'd10;

  // D to X pipeline register
  typedef struct packed {
    word_t pc;
    word_t branch_targ;
    word_t op0;
    word_t op1;
    word_t store_data;
  } x_stage_t;

  // Immediates decoded from one instruction
  typedef struct packed {
    word_t shamt;
    word_t imm_i;
    word_t imm_s;
    word_t imm_sb;
    word_t imm_u;
    word_t imm_uj;
  } imm_t;

endpackage

//--- hw/rv_inst_fields.sv
`timescale 1ns/1ns
// RV32I field extraction; immediates are sign extended, shamt zero extended
// Opcode and rd bits are decoded by the controller, not here
module rv_inst_fields import rv_dpath_pkg::*; (
  input  word_t    inst,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output imm_t     imm
);

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  always_comb begin
    imm.shamt = {27'b0, inst[24:20]};

    // I and S share the upper sign bits
    imm.imm_i = {{20{inst[31]}}, inst[31:20]};
    imm.imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};

    // Branch offset is in halfwords
    imm.imm_sb = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    imm.imm_u = {inst[31:12], 12'b0};

    // Jump offset, also halfword aligned
    imm.imm_uj = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  end

endmodule

//--- hw/rv_regfile.sv
`timescale 1ns/1ns
// 32 x 32 register file, two combinational reads and one clocked write
// x0 always reads zero; writes to it are dropped
module rv_regfile import rv_dpath_pkg::*; (
  input  logic     clk,
  input  reg_idx_t raddr0,
  output word_t    rdata0,
  input  reg_idx_t raddr1,
  output word_t    rdata1,
  input  logic     wen,
  input  reg_idx_t waddr,
  input  word_t    wdata
);

  word_t regs [32];

  // Read ports
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  // Write port
  always_ff @(posedge clk) begin
    if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

//--- hw/rv_execute.sv
`timescale 1ns/1ns
// Scalar ALU plus branch flags; flags are valid only when fn is ALU_SUB
module rv_execute import rv_dpath_pkg::*; (
  input  word_t   op0,
  input  word_t   op1,
  input  alu_fn_t fn,
  output word_t   result,
  output logic    branch_cond_eq,
  output logic    branch_cond_ne,
  output logic    branch_cond_lt,
  output logic    branch_cond_ltu,
  output logic    branch_cond_ge,
  output logic    branch_cond_geu
);

  logic [4:0] shamt;
  logic       diff_signs;

  assign shamt = op1[4:0];

  always_comb begin
    case (fn)
      ALU_ADD:   result = op0 + op1;
      ALU_SUB:   result = op0 - op1;
      ALU_SLL:   result = op0 << shamt;
      ALU_SLT:   result = {31'b0, $signed(op0) < $signed(op1)};
      ALU_SLTU:  result = {31'b0, op0 < op1};
      ALU_XOR:   result = op0 ^ op1;
      ALU_SRL:   result = op0 >> shamt;
      ALU_SRA:   result = word_t'($signed(op0) >>> shamt);
      ALU_OR:    result = op0 | op1;
      ALU_AND:   result = op0 & op1;
      ALU_COPY1: result = op1;
      default:   result = '0;
    endcase
  end

  // ------------------------------------------------------------------
  // Branch conditions
  // ------------------------------------------------------------------

  // With differing signs the subtraction can overflow, so the
  // operand sign bits decide instead of the difference
  assign diff_signs      = op0[31] ^ op1[31];
  assign branch_cond_eq  = (result == '0);
  assign branch_cond_ne  = ~branch_cond_eq;
  assign branch_cond_lt  = diff_signs ? op0[31] : result[31];
  assign branch_cond_ltu = diff_signs ? op1[31] : result[31];
  assign branch_cond_ge  = diff_signs ? op1[31] : ~result[31];
  assign branch_cond_geu = diff_signs ? op0[31] : ~result[31];

endmodule

//--- hw/rv_load_align.sv
`timescale 1ns/1ns
// M-stage load extension, one-entry response holding register and
// writeback select; the held word has no reset and is valid only after a load
module rv_load_align import rv_dpath_pkg::*; (
  input  logic      clk,
  input  word_t     resp_data,
  input  load_sel_t sel,
  input  logic      queue_en,
  input  logic      queue_val,
  input  logic      wb_sel,
  input  word_t     exec_result,
  output word_t     wb_data
);

  word_t load_ext;
  word_t held_q;
  word_t load_data;

  // Subword extension
  always_comb begin
    case (sel)
      LD_B:    load_ext = {{24{resp_data[7]}}, resp_data[7:0]};
      LD_BU:   load_ext = {24'b0, resp_data[7:0]};
      LD_H:    load_ext = {{16{resp_data[15]}}, resp_data[15:0]};
      LD_HU:   load_ext = {16'b0, resp_data[15:0]};
      default: load_ext = resp_data;
    endcase
  end

  // Holds a response that arrived while M was stalled
  always_ff @(posedge clk) begin
    if (queue_en) begin
      held_q <= load_ext;
    end
  end

  assign load_data = queue_val ? held_q : load_ext;
  assign wb_data   = wb_sel ? load_data : exec_result;

endmodule

//--- hw/rv_core_dpath.sv
`timescale 1ns/1ns
// Seven-stage scalar datapath; the controller drives every select, stall and enable
// Only the fetch PC resets; other stage registers are unknown until filled
module rv_core_dpath import rv_dpath_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  word_t     inst,
  input  pc_sel_t   pc_mux_sel,
  input  op0_sel_t  op0_mux_sel,
  input  op1_sel_t  op1_mux_sel,
  input  byp_sel_t  rdata0_byp_sel,
  input  byp_sel_t  rdata1_byp_sel,
  input  alu_fn_t   alu_fn,
  input  load_sel_t dmemresp_sel,
  input  logic      dmemresp_queue_en,
  input  logic      dmemresp_queue_val,
  input  logic      wb_mux_sel,
  input  logic      rf_wen,
  input  reg_idx_t  rf_waddr,
  input  logic      stall_f,
  input  logic      stall_d,
  input  logic      stall_x,
  input  logic      stall_m,
  input  logic      stall_x2,
  input  logic      stall_x3,
  input  logic      stall_w,
  input  word_t     dmemresp_data,
  output word_t     imemreq_addr,
  output word_t     dmemreq_addr,
  output word_t     dmemreq_data,
  output word_t     proc2csr_data,
  output logic      branch_cond_eq,
  output logic      branch_cond_ne,
  output logic      branch_cond_lt,
  output logic      branch_cond_ltu,
  output logic      branch_cond_ge,
  output logic      branch_cond_geu
);

  word_t    pc_f, pc_plus4_f, pc_mux_out;
  word_t    pc_d, pc_plus4_d;
  word_t    branch_targ_d, jump_targ_d, jumpreg_targ_d;
  reg_idx_t rs1_d, rs2_d;
  imm_t     imm_d;
  word_t    rf_rdata0, rf_rdata1, rdata0_byp, rdata1_byp;
  x_stage_t x_d, x_q;
  word_t    alu_out_x, exec_m, wb_m, wb_x2, wb_x3, wb_w;

  // Picks one forwarding source for a D-stage read operand
  function automatic word_t byp_mux(input byp_sel_t sel, input word_t rf_val,
                                    input word_t x_val, input word_t m_val,
                                    input word_t x2_val, input word_t x3_val,
                                    input word_t w_val);
    case (sel)
      BYP_X:   return x_val;
      BYP_M:   return m_val;
      BYP_X2:  return x2_val;
      BYP_X3:  return x3_val;
      BYP_W:   return w_val;
      default: return rf_val;
    endcase
  endfunction

  // ------------------------------------------------------------------
  // P and F stages
  // ------------------------------------------------------------------

  always_comb begin
    case (pc_mux_sel)
      PC_BRANCH:  pc_mux_out = x_q.branch_targ;
      PC_JUMP:    pc_mux_out = jump_targ_d;
      PC_JUMPREG: pc_mux_out = jumpreg_targ_d;
      default:    pc_mux_out = pc_plus4_f;
    endcase
  end

  // Request goes out in P, ahead of the F register
  assign imemreq_addr = reset ? RESET_VECTOR : pc_mux_out;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= RESET_VECTOR;
    end else if (!stall_f) begin
      pc_f <= pc_mux_out;
    end
  end

  assign pc_plus4_f = pc_f + 32'd4;

  always_ff @(posedge clk) begin
    if (!stall_d) begin
      pc_d       <= pc_f;
      pc_plus4_d <= pc_plus4_f;
    end
  end

  // ------------------------------------------------------------------
  // D stage
  // ------------------------------------------------------------------

  assign branch_targ_d  = pc_d + imm_d.imm_sb;
  assign jump_targ_d    = pc_d + imm_d.imm_uj;
  assign jumpreg_targ_d = (rdata0_byp + imm_d.imm_i) & ~32'd1;

  assign rdata0_byp = byp_mux(rdata0_byp_sel, rf_rdata0, alu_out_x, wb_m, wb_x2, wb_x3, wb_w);
  assign rdata1_byp = byp_mux(rdata1_byp_sel, rf_rdata1, alu_out_x, wb_m, wb_x2, wb_x3, wb_w);

  always_comb begin
    x_d.pc          = pc_d;
    x_d.branch_targ = branch_targ_d;
    x_d.store_data  = rdata1_byp;

    case (op0_mux_sel)
      OP0_PC:   x_d.op0 = pc_d;
      OP0_PC4:  x_d.op0 = pc_plus4_d;
      OP0_ZERO: x_d.op0 = '0;
      default:  x_d.op0 = rdata0_byp;
    endcase

    case (op1_mux_sel)
      OP1_SHAMT:  x_d.op1 = imm_d.shamt;
      OP1_IMM_U:  x_d.op1 = imm_d.imm_u;
      OP1_IMM_SB: x_d.op1 = imm_d.imm_sb;
      OP1_IMM_I:  x_d.op1 = imm_d.imm_i;
      OP1_IMM_S:  x_d.op1 = imm_d.imm_s;
      OP1_ZERO:   x_d.op1 = '0;
      default:    x_d.op1 = rdata1_byp;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!stall_x) begin
      x_q <= x_d;
    end
  end

  // ------------------------------------------------------------------
  // X stage; memory request leaves here, response returns in M
  // ------------------------------------------------------------------

  assign dmemreq_addr = alu_out_x;
  assign dmemreq_data = x_q.store_data;

  always_ff @(posedge clk) begin
    if (!stall_m) begin
      exec_m <= alu_out_x;
    end
  end

  // ------------------------------------------------------------------
  // X2, X3 and W are plain delay stages
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!stall_x2) wb_x2 <= wb_m;
    if (!stall_x3) wb_x3 <= wb_x2;
    if (!stall_w)  wb_w  <= wb_x3;
  end

  assign proc2csr_data = wb_w;

  rv_inst_fields u_fields (
    .inst (inst),
    .rs1  (rs1_d),
    .rs2  (rs2_d),
    .imm  (imm_d)
  );

  rv_regfile u_regfile (
    .clk    (clk),
    .raddr0 (rs1_d),
    .rdata0 (rf_rdata0),
    .raddr1 (rs2_d),
    .rdata1 (rf_rdata1),
    .wen    (rf_wen),
    .waddr  (rf_waddr),
    .wdata  (wb_w)
  );

  rv_execute u_execute (
    .op0             (x_q.op0),
    .op1             (x_q.op1),
    .fn              (alu_fn),
    .result          (alu_out_x),
    .branch_cond_eq  (branch_cond_eq),
    .branch_cond_ne  (branch_cond_ne),
    .branch_cond_lt  (branch_cond_lt),
    .branch_cond_ltu (branch_cond_ltu),
    .branch_cond_ge  (branch_cond_ge),
    .branch_cond_geu (branch_cond_geu)
  );

  rv_load_align u_load_align (
    .clk         (clk),
    .resp_data   (dmemresp_data),
    .sel         (dmemresp_sel),
    .queue_en    (dmemresp_queue_en),
    .queue_val   (dmemresp_queue_val),
    .wb_sel      (wb_mux_sel),
    .exec_result (exec_m),
    .wb_data     (wb_m)
  );

endmodule

//--- test/rv_core_dpath_tb.sv
`timescale 1ns/1ns
// Testbench for the scalar datapath; the stimulus plays the external controller
// Only stall_f is ever raised; the other stages always advance
module rv_core_dpath_tb import rv_dpath_pkg::*; ();

  localparam int CLK_PERIOD  = 10;
  localparam int TEST_CYCLES = 260;

  logic      clk, reset;
  word_t     inst, dmemresp_data;
  pc_sel_t   pc_mux_sel;
  op0_sel_t  op0_mux_sel;
  op1_sel_t  op1_mux_sel;
  byp_sel_t  rdata0_byp_sel, rdata1_byp_sel;
  alu_fn_t   alu_fn;
  load_sel_t dmemresp_sel;
  logic      dmemresp_queue_en, dmemresp_queue_val, wb_mux_sel, rf_wen;
  reg_idx_t  rf_waddr;
  logic      stall_f, stall_d, stall_x, stall_m, stall_x2, stall_x3, stall_w;
  word_t     imemreq_addr, dmemreq_addr, dmemreq_data, proc2csr_data;
  logic      branch_cond_eq, branch_cond_ne, branch_cond_lt;
  logic      branch_cond_ltu, branch_cond_ge, branch_cond_geu;
  logic [5:0] flags;

  int        seed = 32'hb7462a79;
  int        errors, checks, cyc;
  word_t     pc_f_m, pc_d_m, btarg_m, next_pc;
  word_t     rf_m [32];

  // Pending expectations and late-stage controls in slots of cycle modulo 16
  word_t      daddr_q [16], ddata_q [16], csr_q [16];
  logic       daddr_v [16], ddata_v [16], csr_v [16], flags_v [16];
  logic [5:0] flags_q [16];
  alu_fn_t    fn_q [16];
  logic       wen_q [16];
  reg_idx_t   waddr_q [16];

  // Armed for the coming rising edge
  logic       chk_daddr, chk_ddata, chk_flags, chk_csr;
  word_t      want_imem, want_daddr, want_ddata, want_csr;
  logic [5:0] want_flags;

  assign flags = {branch_cond_eq, branch_cond_ne, branch_cond_lt,
                  branch_cond_ltu, branch_cond_ge, branch_cond_geu};

  rv_core_dpath DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  assert property (@(posedge clk) imemreq_addr === want_imem)
    else report_mismatch("imemreq_addr", want_imem, $sampled(imemreq_addr));
  assert property (@(posedge clk) chk_daddr |-> dmemreq_addr === want_daddr)
    else report_mismatch("dmemreq_addr", want_daddr, $sampled(dmemreq_addr));
  assert property (@(posedge clk) chk_ddata |-> dmemreq_data === want_ddata)
    else report_mismatch("dmemreq_data", want_ddata, $sampled(dmemreq_data));
  assert property (@(posedge clk) chk_csr |-> proc2csr_data === want_csr)
    else report_mismatch("proc2csr_data", want_csr, $sampled(proc2csr_data));
  assert property (@(posedge clk) chk_flags |-> flags === want_flags)
    else report_mismatch("branch_cond_{eq,ne,lt,ltu,ge,geu}", {26'b0, want_flags},
                         {26'b0, $sampled(flags)});

  task automatic report_mismatch(input string name, input word_t want, input word_t got);
    errors++;
    $display("** Error at %0t ns: %s expected %h, got %h", $time, name, want, got);
  endtask

  // ------------------------------------------------------------------
  // Reference rules
  // ------------------------------------------------------------------

  function automatic word_t alu_ref(input alu_fn_t fn, input word_t a, input word_t b);
    case (fn)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << b[4:0];
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      default:  return b;
    endcase
  endfunction

  // Flag order eq, ne, lt, ltu, ge, geu
  function automatic logic [5:0] flags_ref(input word_t a, input word_t b);
    logic lt, ltu;
    lt  = $signed(a) < $signed(b);
    ltu = a < b;
    return {a == b, a != b, lt, ltu, !lt, !ltu};
  endfunction

  function automatic word_t load_ref(input load_sel_t sel, input word_t d);
    case (sel)
      LD_B:    return word_t'($signed(d[7:0]));
      LD_BU:   return word_t'(d[7:0]);
      LD_H:    return word_t'($signed(d[15:0]));
      LD_HU:   return word_t'(d[15:0]);
      default: return d;
    endcase
  endfunction

  function automatic word_t imm_i_of(input word_t i);
    return word_t'($signed(i[31:20]));
  endfunction

  function automatic word_t imm_sb_of(input word_t i);
    return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
  endfunction

  function automatic word_t imm_uj_of(input word_t i);
    return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1);
    return {imm, rs1, 3'b000, 5'b00000, 7'h13};
  endfunction

  function automatic word_t enc_r(input reg_idx_t rs1, input reg_idx_t rs2);
    return {7'b0, rs2, rs1, 3'b000, 5'b00000, 7'h33};
  endfunction

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  function automatic reg_idx_t rand_reg(input int lo, input int hi);
    int r;
    r = $random(seed);
    r = lo + ((r & 32'h7fffffff) % (hi - lo + 1));
    return reg_idx_t'(r);
  endfunction

  // ------------------------------------------------------------------
  // Cycle sequencing
  // ------------------------------------------------------------------

  // Arms this cycle's checks, steps the PC model, applies late controls
  task automatic tick();
    int s;
    s = cyc & 15;
    want_imem  = reset ? RESET_VECTOR : next_pc;
    chk_daddr  = daddr_v[s];
    want_daddr = daddr_q[s];
    chk_ddata  = ddata_v[s];
    want_ddata = ddata_q[s];
    chk_flags  = flags_v[s];
    want_flags = flags_q[s];
    chk_csr    = csr_v[s];
    want_csr   = csr_q[s];
    daddr_v[s] = 1'b0;
    ddata_v[s] = 1'b0;
    flags_v[s] = 1'b0;
    csr_v[s]   = 1'b0;
    checks     = checks + 1 + int'($countones({chk_daddr, chk_ddata, chk_flags, chk_csr}));
    @(posedge clk);
    btarg_m = pc_d_m + imm_sb_of(inst);
    pc_d_m  = pc_f_m;
    if (reset) begin
      pc_f_m = RESET_VECTOR;
    end else if (!stall_f) begin
      pc_f_m = next_pc;
    end
    @(negedge clk);
    cyc++;
    s          = cyc & 15;
    next_pc    = pc_f_m + 32'd4;
    pc_mux_sel = PC_PLUS4;
    alu_fn     = fn_q[s];
    rf_wen     = wen_q[s];
    rf_waddr   = waddr_q[s];
    fn_q[s]    = ALU_ADD;
    wen_q[s]   = 1'b0;
  endtask

  task automatic expect_csr(input int delay, input word_t val);
    csr_q[(cyc + delay) & 15] = val;
    csr_v[(cyc + delay) & 15] = 1'b1;
  endtask

  // Puts one instruction into D; a and b are the operand values it must see
  task automatic issue(input word_t instr, input op0_sel_t s0, input op1_sel_t s1,
                       input byp_sel_t b0, input byp_sel_t b1, input alu_fn_t fn,
                       input word_t a, input word_t b, input logic wr, input reg_idx_t rd);
    word_t res;
    int    sx;
    res            = alu_ref(fn, a, b);
    sx             = (cyc + 1) & 15;
    inst           = instr;
    op0_mux_sel    = s0;
    op1_mux_sel    = s1;
    rdata0_byp_sel = b0;
    rdata1_byp_sel = b1;
    fn_q[sx]       = fn;
    daddr_q[sx]    = res;
    daddr_v[sx]    = 1'b1;
    if (s1 == OP1_RS2) begin
      ddata_q[sx] = b;
      ddata_v[sx] = 1'b1;
    end
    if (fn == ALU_SUB) begin
      flags_q[sx] = flags_ref(a, b);
      flags_v[sx] = 1'b1;
    end
    expect_csr(5, res);
    if (wr) begin
      wen_q[(cyc + 5) & 15]   = 1'b1;
      waddr_q[(cyc + 5) & 15] = rd;
      if (rd != 5'd0) begin
        rf_m[rd] = res;
      end
    end
    tick();
  endtask

  task automatic issue_nop();
    issue(enc_i(12'd0, 5'd0), OP0_ZERO, OP1_IMM_I, BYP_RF, BYP_RF, ALU_ADD, '0, '0,
          1'b0, 5'd0);
  endtask

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------

  initial begin
    word_t     rv, ins;
    reg_idx_t  r1, r2, r3, dst;
    load_sel_t ls;
    reset              = 1'b1;
    inst               = '0;
    pc_mux_sel         = PC_PLUS4;
    op0_mux_sel        = OP0_ZERO;
    op1_mux_sel        = OP1_ZERO;
    rdata0_byp_sel     = BYP_RF;
    rdata1_byp_sel     = BYP_RF;
    alu_fn             = ALU_ADD;
    dmemresp_sel       = LD_W;
    dmemresp_queue_en  = 1'b0;
    dmemresp_queue_val = 1'b0;
    wb_mux_sel         = 1'b0;
    rf_wen             = 1'b0;
    rf_waddr           = '0;
    {stall_f, stall_d, stall_x, stall_m, stall_x2, stall_x3, stall_w} = '0;
    dmemresp_data      = '0;
    errors             = 0;
    checks             = 0;
    cyc                = 0;
    pc_f_m             = RESET_VECTOR;
    pc_d_m             = RESET_VECTOR;
    btarg_m            = '0;
    next_pc            = RESET_VECTOR + 32'd4;
    for (int i = 0; i < 16; i++) begin
      {daddr_v[i], ddata_v[i], flags_v[i], csr_v[i], wen_q[i]} = '0;
      fn_q[i] = ALU_ADD;
    end
    for (int i = 0; i < 32; i++) begin
      rf_m[i] = '0;
    end

    repeat (4) tick();
    reset = 1'b0;

    // Sequential fetch, then a held fetch PC
    repeat (8) tick();
    stall_f = 1'b1;
    repeat (3) tick();
    stall_f = 1'b0;
    tick();

    // Jump from D, then the branch target registered in X
    for (int i = 0; i < 8; i++) begin
      inst       = rand_word();
      pc_mux_sel = PC_JUMP;
      next_pc    = pc_d_m + imm_uj_of(inst);
      tick();
      pc_mux_sel = PC_BRANCH;
      next_pc    = btarg_m;
      tick();
      tick();
    end

    // Fill x1..x31 with odd ones through the U immediate; x0 ignores its write
    for (int r = 1; r < 32; r++) begin
      rv = rand_word();
      if (r[0]) begin
        ins = {rv[31:12], 5'd0, 7'h37};
        issue(ins, OP0_ZERO, OP1_IMM_U, BYP_RF, BYP_RF, ALU_ADD, '0, {rv[31:12], 12'b0},
              1'b1, reg_idx_t'(r));
      end else begin
        ins = enc_i(rv[11:0], 5'd0);
        issue(ins, OP0_ZERO, OP1_IMM_I, BYP_RF, BYP_RF, ALU_ADD, '0, imm_i_of(ins),
              1'b1, reg_idx_t'(r));
      end
    end
    ins = enc_i(12'h5a5, 5'd0);
    issue(ins, OP0_ZERO, OP1_IMM_I, BYP_RF, BYP_RF, ALU_ADD, '0, imm_i_of(ins), 1'b1, 5'd0);
    repeat (6) tick();

    // Every ALU function on register pairs including x0
    for (int f = 0; f <= 10; f++) begin
      repeat (4) begin
        r1 = rand_reg(0, 31);
        r2 = rand_reg(0, 31);
        issue(enc_r(r1, r2), OP0_RS1, OP1_RS2, BYP_RF, BYP_RF, alu_fn_t'(f), rf_m[r1],
              rf_m[r2], 1'b0, 5'd0);
      end
    end
    r2 = rand_reg(1, 31);
    issue(enc_r(5'd0, r2), OP0_RS1, OP1_RS2, BYP_RF, BYP_RF, ALU_ADD, '0, rf_m[r2],
          1'b0, 5'd0);

    // Jump through a register
    repeat (4) begin
      r1         = rand_reg(1, 31);
      rv         = rand_word();
      ins        = enc_i(rv[11:0], r1);
      pc_mux_sel = PC_JUMPREG;
      next_pc    = (rf_m[r1] + imm_i_of(ins)) & ~32'd1;
      issue(ins, OP0_RS1, OP1_IMM_I, BYP_RF, BYP_RF, ALU_ADD, rf_m[r1], imm_i_of(ins),
            1'b0, 5'd0);
    end
    repeat (6) tick();

    // Dependent pair k apart uses bypass code k; k = 6 reads the register file
    for (int k = 1; k <= 6; k++) begin
      for (int side = 0; side < 2; side++) begin
        r1  = rand_reg(1, 23);
        r2  = rand_reg(1, 23);
        r3  = rand_reg(1, 23);
        dst = rand_reg(24, 31);
        issue(enc_r(r1, r2), OP0_RS1, OP1_RS2, BYP_RF, BYP_RF, ALU_ADD, rf_m[r1],
              rf_m[r2], 1'b1, dst);
        repeat (k - 1) issue_nop();
        if (side == 0) begin
          issue(enc_r(dst, r3), OP0_RS1, OP1_RS2, byp_sel_t'(k % 6), BYP_RF, ALU_ADD,
                rf_m[dst], rf_m[r3], 1'b0, 5'd0);
        end else begin
          issue(enc_r(r3, dst), OP0_RS1, OP1_RS2, BYP_RF, byp_sel_t'(k % 6), ALU_ADD,
                rf_m[r3], rf_m[dst], 1'b0, 5'd0);
        end
      end
    end
    repeat (6) tick();

    // Branch flags where every third pair compares a register with itself
    for (int i = 0; i < 24; i++) begin
      r1 = rand_reg(1, 31);
      r2 = (i % 3 == 0) ? r1 : rand_reg(1, 31);
      issue(enc_r(r1, r2), OP0_RS1, OP1_RS2, BYP_RF, BYP_RF, ALU_SUB, rf_m[r1], rf_m[r2],
            1'b0, 5'd0);
    end
    repeat (6) tick();

    // Load extension in M
    wb_mux_sel = 1'b1;
    for (int i = 0; i < 20; i++) begin
      ls            = load_sel_t'(i % 5);
      rv            = rand_word();
      dmemresp_sel  = ls;
      dmemresp_data = rv;
      expect_csr(3, load_ref(ls, rv));
      tick();
    end

    // Captured response wins over the live one while queue_val is high
    for (int i = 0; i < 4; i++) begin
      ls                = load_sel_t'(rand_reg(0, 4));
      rv                = rand_word();
      dmemresp_sel      = ls;
      dmemresp_data     = rv;
      dmemresp_queue_en = 1'b1;
      expect_csr(3, load_ref(ls, rv));
      tick();
      dmemresp_queue_en  = 1'b0;
      dmemresp_queue_val = 1'b1;
      repeat (2) begin
        dmemresp_sel  = load_sel_t'(rand_reg(0, 4));
        dmemresp_data = rand_word();
        expect_csr(3, load_ref(ls, rv));
        tick();
      end
      dmemresp_queue_val = 1'b0;
    end
    wb_mux_sel = 1'b0;
    repeat (4) tick();

    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #((TEST_CYCLES + 200) * CLK_PERIOD);
    $display("Timeout: stimulus did not finish within %0d cycles", TEST_CYCLES + 200);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- all.f
hw/rv_dpath_pkg.sv
hw/rv_inst_fields.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_load_align.sv
hw/rv_core_dpath.sv
test/rv_core_dpath_tb.sv

//--- Makefile
# Verilator lint and simulation of the scalar datapath testbench
TOP := rv_core_dpath_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f all.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then \
		echo "Simulation reported failures"; exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" sim.log || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log
